// File: logic/vita_tx_macros.svh
`ifndef VITA_TX_MACROS_SVH
`define VITA_TX_MACROS_SVH

`define VITA_SAMPLE_W 32
`define VITA_TIME_W 64

// settings bus
`define VITA_SET_ADDR_W 8
`define VITA_SET_DATA_W 32

`define VITA_SR_TIME_HI 8'd0
`define VITA_SR_TIME_LO 8'd1
`define VITA_SR_CLEAR 8'd2

// 2^20 ticks, anything further out is treated as bogus
`define VITA_MAX_LEAD 64'd1048576

`endif

// File: logic/vita_time_pkg.sv
`default_nettype none

`include "vita_tx_macros.svh"

package vita_time_pkg;

   typedef logic [`VITA_TIME_W-1:0] vita_time_t;   // radio ticks

   // result of a trigger time vs current time check
   typedef struct packed {
      logic now;
      logic early;
      logic late;
      logic too_early;   // early by more than max lead
   } time_cmp_t;

endpackage

`default_nettype wire

// File: logic/vita_tx_pkg.sv
`default_nettype none

`include "vita_tx_macros.svh"

package vita_tx_pkg;

   typedef logic [`VITA_SAMPLE_W-1:0] sample_t;

   // one queued sample and its burst flags
   typedef struct packed {
      logic                      send_at;   // hold until send_time
      logic                      sob;
      logic                      eob;
      logic                      eop;       // carried, not acted on
      sample_t                   sample;
      vita_time_pkg::vita_time_t send_time;
   } tx_entry_t;

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      UNDERRUN
   } tx_state_e;

endpackage

`default_nettype wire

// File: logic/setting_reg.sv
`default_nettype none

`include "vita_tx_macros.svh"

module setting_reg #(
   parameter logic [`VITA_SET_ADDR_W-1:0] ADDR = '0
) (
   input  wire                         clk,
   input  wire                         reset_i,
   input  wire                         set_stb_i,
   input  wire [`VITA_SET_ADDR_W-1:0]  set_addr_i,
   input  wire [`VITA_SET_DATA_W-1:0]  set_data_i,
   output logic [`VITA_SET_DATA_W-1:0] value_o,
   output logic                        changed_o
);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == ADDR);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         value_o   <= '0;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;   // one cycle per write
         if (hit) begin
            value_o <= set_data_i;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/time_compare.sv
`default_nettype none

`include "vita_tx_macros.svh"

module time_compare (
   input  wire vita_time_pkg::vita_time_t time_now_i,
   input  wire vita_time_pkg::vita_time_t trigger_i,
   output vita_time_pkg::time_cmp_t       cmp_o
);

   vita_time_pkg::vita_time_t lead;

   assign lead = trigger_i - time_now_i;   // only meaningful when early

   always_comb begin
      cmp_o.now       = (trigger_i == time_now_i);
      cmp_o.early     = (trigger_i > time_now_i);
      cmp_o.late      = (trigger_i < time_now_i);
      cmp_o.too_early = cmp_o.early && (lead > `VITA_MAX_LEAD);
   end

   // head entry is unwritten memory while the FIFO is empty
   always_comb begin
      if (!$isunknown({time_now_i, trigger_i})) begin
         a_one_class: assert final ($onehot({cmp_o.now, cmp_o.early, cmp_o.late}))
            else $error("time_compare: now/early/late not exclusive");
      end
   end

endmodule

`default_nettype wire

// File: logic/vita_time_counter.sv
`default_nettype none

`include "vita_tx_macros.svh"

module vita_time_counter (
   input  wire                        clk,
   input  wire                        reset_i,
   input  wire                        set_stb_i,
   input  wire [`VITA_SET_ADDR_W-1:0] set_addr_i,
   input  wire [`VITA_SET_DATA_W-1:0] set_data_i,
   output vita_time_pkg::vita_time_t  vita_time_o
);

   logic [`VITA_SET_DATA_W-1:0] time_hi;
   logic [`VITA_SET_DATA_W-1:0] time_lo;
   logic                        load;

   // hi is only staged, the lo write commits both halves
   setting_reg #(.ADDR(`VITA_SR_TIME_HI)) u_sr_time_hi (
      .clk        (clk),
      .reset_i    (reset_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .value_o    (time_hi),
      .changed_o  ()
   );

   setting_reg #(.ADDR(`VITA_SR_TIME_LO)) u_sr_time_lo (
      .clk        (clk),
      .reset_i    (reset_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .value_o    (time_lo),
      .changed_o  (load)
   );

   always_ff @(posedge clk) begin
      if (reset_i) begin
         vita_time_o <= '0;
      end else if (load) begin
         vita_time_o <= {time_hi, time_lo};
      end else begin
         vita_time_o <= vita_time_o + 1'b1;   // free running
      end
   end

endmodule

`default_nettype wire

// File: logic/sample_fifo.sv
`default_nettype none

module sample_fifo #(
   parameter int DEPTH_LOG2 = 4
) (
   input  wire                         clk,
   input  wire                         reset_i,
   input  wire                         wr_i,
   input  wire vita_tx_pkg::tx_entry_t wr_entry_i,
   output logic                        full_o,
   output vita_tx_pkg::tx_entry_t      head_o,
   output logic                        src_rdy_o,
   input  wire                         dst_rdy_i
);

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   typedef logic [DEPTH_LOG2:0]   ptr_t;    // msb is the wrap bit
   typedef logic [DEPTH_LOG2-1:0] addr_t;

   vita_tx_pkg::tx_entry_t mem [DEPTH];

   ptr_t  wr_ptr;
   ptr_t  rd_ptr;
   addr_t wr_addr;
   addr_t rd_addr;
   logic  empty;

   assign wr_addr = wr_ptr[DEPTH_LOG2-1:0];
   assign rd_addr = rd_ptr[DEPTH_LOG2-1:0];

   always_ff @(posedge clk) begin
      if (wr_i) begin
         mem[wr_addr] <= wr_entry_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (dst_rdy_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   assign empty     = (wr_ptr == rd_ptr);
   assign full_o    = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) && (wr_addr == rd_addr);
   assign src_rdy_o = !empty;
   assign head_o    = mem[rd_addr];   // show-ahead

   // writer and reader must both honour the flags
   a_no_overflow: assert property (
      @(posedge clk) disable iff (reset_i) wr_i |-> !full_o)
      else $error("sample_fifo: write while full");

   a_no_underflow: assert property (
      @(posedge clk) disable iff (reset_i) dst_rdy_i |-> src_rdy_o)
      else $error("sample_fifo: pop while empty");

endmodule

`default_nettype wire

// File: logic/vita_tx_control.sv
`default_nettype none

`include "vita_tx_macros.svh"

module vita_tx_control (
   input  wire                         clk,
   input  wire                         reset_i,
   input  wire                         set_stb_i,
   input  wire [`VITA_SET_ADDR_W-1:0]  set_addr_i,
   input  wire [`VITA_SET_DATA_W-1:0]  set_data_i,
   input  wire vita_time_pkg::vita_time_t vita_time_i,
   input  wire vita_tx_pkg::tx_entry_t head_i,
   input  wire                         src_rdy_i,
   output logic                        dst_rdy_o,
   output vita_tx_pkg::sample_t        sample_o,
   output logic                        run_o,
   output logic                        underrun_o,
   input  wire                         strobe_i
);

   vita_time_pkg::time_cmp_t cmp;
   vita_tx_pkg::tx_state_e   state_q;
   vita_tx_pkg::tx_state_e   state_d;
   logic                     clear_state;

   time_compare u_time_compare (
      .time_now_i (vita_time_i),
      .trigger_i  (head_i.send_time),
      .cmp_o      (cmp)
   );

   // data of a CLEAR write is ignored
   setting_reg #(.ADDR(`VITA_SR_CLEAR)) u_sr_clear (
      .clk        (clk),
      .reset_i    (reset_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .value_o    (),
      .changed_o  (clear_state)
   );

   always_comb begin
      state_d = state_q;
      case (state_q)
         vita_tx_pkg::IDLE: begin
            if (src_rdy_i) begin
               if (!head_i.send_at || cmp.now) begin
                  state_d = vita_tx_pkg::RUN;
               end else if (cmp.late || cmp.too_early) begin
                  state_d = vita_tx_pkg::UNDERRUN;
               end
            end
         end
         vita_tx_pkg::RUN: begin
            if (strobe_i) begin
               if (!src_rdy_i) begin
                  state_d = vita_tx_pkg::UNDERRUN;   // starved mid burst
               end else if (head_i.eob) begin
                  state_d = vita_tx_pkg::IDLE;
               end
            end
         end
         vita_tx_pkg::UNDERRUN: begin
            state_d = vita_tx_pkg::UNDERRUN;   // sticky until clear
         end
         default: begin
            state_d = vita_tx_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i || clear_state) begin
         state_q <= vita_tx_pkg::IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign run_o      = (state_q == vita_tx_pkg::RUN);
   assign underrun_o = (state_q == vita_tx_pkg::UNDERRUN);
   assign sample_o   = head_i.sample;
   assign dst_rdy_o  = strobe_i && run_o && src_rdy_i;   // empty strobe pops nothing

   a_pop_in_run: assert property (
      @(posedge clk) disable iff (reset_i) dst_rdy_o |-> run_o)
      else $error("vita_tx_control: pop outside RUN");

endmodule

`default_nettype wire

// File: logic/vita_tx_top.sv
`default_nettype none

`include "vita_tx_macros.svh"

module vita_tx_top (
   input  wire                         clk,
   input  wire                         reset_i,
   input  wire                         set_stb_i,
   input  wire [`VITA_SET_ADDR_W-1:0]  set_addr_i,
   input  wire [`VITA_SET_DATA_W-1:0]  set_data_i,
   input  wire                         in_valid_i,
   input  wire vita_tx_pkg::tx_entry_t in_entry_i,
   output logic                        in_ready_o,
   input  wire                         strobe_i,
   output vita_tx_pkg::sample_t        sample_o,
   output logic                        run_o,
   output logic                        underrun_o,
   output vita_time_pkg::vita_time_t   vita_time_o
);

   vita_tx_pkg::tx_entry_t head;
   logic                   fifo_full;
   logic                   fifo_wr;
   logic                   src_rdy;
   logic                   dst_rdy;

   assign in_ready_o = !fifo_full;
   assign fifo_wr    = in_valid_i && !fifo_full;

   vita_time_counter u_vita_time_counter (
      .clk         (clk),
      .reset_i     (reset_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .vita_time_o (vita_time_o)
   );

   sample_fifo u_sample_fifo (
      .clk        (clk),
      .reset_i    (reset_i),
      .wr_i       (fifo_wr),
      .wr_entry_i (in_entry_i),
      .full_o     (fifo_full),
      .head_o     (head),
      .src_rdy_o  (src_rdy),
      .dst_rdy_i  (dst_rdy)
   );

   vita_tx_control u_vita_tx_control (
      .clk         (clk),
      .reset_i     (reset_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .vita_time_i (vita_time_o),
      .head_i      (head),
      .src_rdy_i   (src_rdy),
      .dst_rdy_o   (dst_rdy),
      .sample_o    (sample_o),
      .run_o       (run_o),
      .underrun_o  (underrun_o),
      .strobe_i    (strobe_i)
   );

endmodule

`default_nettype wire

// File: test/vita_tx_checker.sv
`default_nettype none

`include "vita_tx_macros.svh"

module vita_tx_checker (
   input  wire                            clk,
   input  wire                            reset_i,
   input  wire                            set_stb_i,
   input  wire [`VITA_SET_ADDR_W-1:0]     set_addr_i,
   input  wire [`VITA_SET_DATA_W-1:0]     set_data_i,
   input  wire                            in_valid_i,
   input  wire                            in_ready_i,
   input  wire                            strobe_i,
   input  wire vita_tx_pkg::sample_t      sample_i,
   input  wire                            run_i,
   input  wire                            underrun_i,
   input  wire vita_time_pkg::vita_time_t vita_time_i,
   output int                             error_count_o,
   output int                             rows_failed_o
);

   localparam int FIFO_DEPTH = 16;   // sample_fifo default depth

   vita_tx_pkg::sample_t        expected [$];
   vita_time_pkg::vita_time_t   row_send_time;
   vita_time_pkg::vita_time_t   model_time;
   logic [`VITA_SET_DATA_W-1:0] model_hi;
   logic [`VITA_SET_DATA_W-1:0] model_lo;
   logic                        load_pending;
   int                          row_idx;
   int                          row_errors;
   int                          occupancy;
   logic                        row_active;
   logic                        row_timed;
   logic                        row_exp_underrun;
   logic                        row_exp_full;
   logic                        now_seen;
   logic                        start_seen;
   logic                        run_seen;
   logic                        underrun_seen;
   logic                        full_seen;
   logic                        clear_seen;

   initial begin
      error_count_o = 0;
      rows_failed_o = 0;
      row_errors    = 0;
      row_active    = 1'b0;
      occupancy     = 0;
   end

   task automatic count_error();
      error_count_o++;
      row_errors++;
   endtask

   task automatic begin_row(input int idx, input logic timed,
                            input vita_time_pkg::vita_time_t send_time,
                            input logic exp_underrun, input logic exp_full);
      row_idx          = idx;
      row_timed        = timed;
      row_send_time    = send_time;
      row_exp_underrun = exp_underrun;
      row_exp_full     = exp_full;
      {now_seen, start_seen, run_seen, underrun_seen, full_seen, clear_seen} = '0;
      row_errors       = 0;
      row_active       = 1'b1;
   endtask

   task automatic add_sample(input vita_tx_pkg::sample_t sample);
      expected.push_back(sample);
   endtask

   task automatic end_row();
      if (run_i || underrun_i) begin
         $display("row %0d: run_o or underrun_o still high after CLEAR", row_idx);
         count_error();
      end
      if (row_exp_underrun && !underrun_seen) begin
         $display("row %0d: expected an underrun but underrun_o never rose", row_idx);
         count_error();
      end
      if (!row_exp_underrun && underrun_seen) begin
         $display("row %0d: unexpected underrun", row_idx);
         count_error();
      end
      if (!row_exp_underrun && !run_seen) begin
         $display("row %0d: burst never started", row_idx);
         count_error();
      end
      if (row_exp_full && !full_seen) begin
         $display("row %0d: in_ready_o never dropped with the FIFO full", row_idx);
         count_error();
      end
      if (expected.size() != 0) begin
         $display("row %0d: %0d samples never came out", row_idx, expected.size());
         count_error();
         expected.delete();
      end
      if (row_errors == 0) begin
         $display("row %0d: pass", row_idx);
      end else begin
         rows_failed_o++;
         $display("row %0d: fail, %0d errors", row_idx, row_errors);
      end
      row_active = 1'b0;
   endtask

   always @(posedge clk) begin : watch_ports
      logic                 pop;
      vita_tx_pkg::sample_t want;
      pop = strobe_i && run_i && (occupancy > 0);   // an empty strobe pops nothing
      if (reset_i) begin
         occupancy    = 0;
         model_time   = '0;
         model_hi     = '0;
         model_lo     = '0;
         load_pending = 1'b0;
      end else begin
         if (vita_time_i !== model_time) begin
            $display("[FAIL] vita_time_o got 0x%h expected 0x%h", vita_time_i, model_time);
            count_error();
         end
         // a lo write takes effect on the cycle after its changed pulse
         model_time   = load_pending ? {model_hi, model_lo} : model_time + 1'b1;
         load_pending = set_stb_i && (set_addr_i == `VITA_SR_TIME_LO);
         if (set_stb_i && set_addr_i == `VITA_SR_TIME_HI) begin
            model_hi = set_data_i;
         end
         if (load_pending) begin
            model_lo = set_data_i;
         end
         if (in_ready_i !== (occupancy < FIFO_DEPTH)) begin
            $display("[FAIL] in_ready_o got 0x%h expected 0x%h", in_ready_i,
                     occupancy < FIFO_DEPTH);
            count_error();
         end
         if (pop && expected.size() == 0) begin
            $display("sample 0x%h came out with no sample pending", sample_i);
            count_error();
         end else if (pop) begin
            want = expected.pop_front();
            if (sample_i !== want) begin
               $display("[FAIL] sample_o got 0x%h expected 0x%h", sample_i, want);
               count_error();
            end
         end
         if (in_valid_i && in_ready_i) begin
            occupancy++;
         end
         if (pop) begin
            occupancy--;
         end
         if (row_active) begin
            if (underrun_seen && !underrun_i && !clear_seen) begin
               $display("row %0d: underrun_o dropped before CLEAR was written", row_idx);
               count_error();
            end
            clear_seen    = clear_seen || (set_stb_i && set_addr_i == `VITA_SR_CLEAR);
            underrun_seen = underrun_seen || underrun_i;
            run_seen      = run_seen || run_i;
            full_seen     = full_seen || !in_ready_i;
            // run must rise exactly one cycle after the time match
            if (row_timed && !start_seen && run_i) begin
               start_seen = 1'b1;
               if (!now_seen) begin
                  $display("row %0d: run_o rose before the send time", row_idx);
                  count_error();
               end
            end else if (row_timed && !start_seen && now_seen) begin
               start_seen = 1'b1;
               $display("row %0d: burst missed its start time", row_idx);
               count_error();
            end
            now_seen = now_seen || (vita_time_i == row_send_time);
         end
      end
   end

endmodule

`default_nettype wire

// File: test/vita_tx_tb.sv
`default_nettype none

`include "vita_tx_macros.svh"

module vita_tx_tb;

   localparam int NUM_ROWS       = 9;
   localparam int TIMEOUT_CYCLES = NUM_ROWS * 200;

   typedef struct packed {
      vita_time_pkg::vita_time_t load;
      logic [7:0]                len;
      logic                      send_at;
      logic [63:0]               offset;   // signed offset from load
      logic                      gap;      // eob entry held back
      logic                      exp_underrun;
   } row_t;

   logic                        clk;
   logic                        reset_i;
   logic                        set_stb_i;
   logic [`VITA_SET_ADDR_W-1:0] set_addr_i;
   logic [`VITA_SET_DATA_W-1:0] set_data_i;
   logic                        in_valid_i;
   vita_tx_pkg::tx_entry_t      in_entry_i;
   logic                        in_ready_o;
   logic                        strobe_i;
   vita_tx_pkg::sample_t        sample_o;
   logic                        run_o;
   logic                        underrun_o;
   vita_time_pkg::vita_time_t   vita_time_o;
   int                          error_count;
   int                          rows_failed;
   int                          cycle_count;
   integer                      seed;
   logic                        writes_done;
   row_t                        rows [NUM_ROWS];

   vita_tx_top u_vita_tx_top (.*);

   vita_tx_checker u_vita_tx_checker (
      .clk           (clk),
      .reset_i       (reset_i),
      .set_stb_i     (set_stb_i),
      .set_addr_i    (set_addr_i),
      .set_data_i    (set_data_i),
      .in_valid_i    (in_valid_i),
      .in_ready_i    (in_ready_o),
      .strobe_i      (strobe_i),
      .sample_i      (sample_o),
      .run_i         (run_o),
      .underrun_i    (underrun_o),
      .vita_time_i   (vita_time_o),
      .error_count_o (error_count),
      .rows_failed_o (rows_failed)
   );

   initial begin
      clk = 1'b0;
   end

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the rows did not finish", cycle_count);
         $display("sim failed");
         $finish;
      end
   end

   function automatic row_t make_row(input vita_time_pkg::vita_time_t load, input int len,
                                     input logic send_at, input logic [63:0] offset,
                                     input logic gap, input logic exp_underrun);
      row_t row;
      row.load         = load;
      row.len          = len[7:0];
      row.send_at      = send_at;
      row.offset       = offset;
      row.gap          = gap;
      row.exp_underrun = exp_underrun;
      return row;
   endfunction

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge clk);
      set_stb_i  = 1'b0;
   endtask

   // holds the entry until the FIFO has room
   task automatic push_entry(input vita_tx_pkg::tx_entry_t entry);
      @(negedge clk);
      in_valid_i = 1'b1;
      in_entry_i = entry;
      while (!in_ready_o) begin
         @(negedge clk);
      end
   endtask

   task automatic feed_burst(input row_t row);
      vita_tx_pkg::tx_entry_t entry;
      int                     fed;
      fed = row.gap ? row.len - 1 : row.len;
      for (int i = 0; i < fed; i++) begin
         entry           = '0;
         entry.send_at   = row.send_at && (i == 0);
         entry.sob       = (i == 0);
         entry.eob       = (i == row.len - 1);
         entry.eop       = entry.eob;
         entry.sample    = $random(seed);
         entry.send_time = row.load + row.offset;
         if (!row.exp_underrun || row.gap) begin
            u_vita_tx_checker.add_sample(entry.sample);
         end
         push_entry(entry);
      end
      @(negedge clk);
      in_valid_i  = 1'b0;
      writes_done = 1'b1;
   endtask

   task automatic strobe_until_done();
      logic started;
      logic phase;
      logic done;
      started = 1'b0;
      phase   = 1'b0;
      done    = 1'b0;
      while (!done) begin
         @(negedge clk);
         started = started || run_o;
         done    = underrun_o || (started && !run_o);
         phase   = !phase && !done;
         strobe_i = phase;   // every other cycle
      end
   endtask

   task automatic run_row(input int idx);
      row_t row;
      row = rows[idx];
      write_setting(`VITA_SR_TIME_HI, row.load[63:32]);
      write_setting(`VITA_SR_TIME_LO, row.load[31:0]);
      @(negedge clk);   // loaded time now on vita_time_o
      u_vita_tx_checker.begin_row(idx, row.send_at, row.load + row.offset,
                                  row.exp_underrun, row.len > 16);
      writes_done = 1'b0;
      fork
         feed_burst(row);
         begin
            wait (writes_done || !in_ready_o);
            strobe_until_done();
         end
      join
      if (row.exp_underrun) begin
         repeat (4) @(negedge clk);
      end
      write_setting(`VITA_SR_CLEAR, 32'h0);
      @(negedge clk);
      u_vita_tx_checker.end_row();
      // only reset empties a FIFO still holding a stale late head
      if (row.exp_underrun && !row.gap) begin
         reset_i = 1'b1;
         repeat (2) @(negedge clk);
         reset_i = 1'b0;
      end
   endtask

   initial begin
      seed        = 67;
      cycle_count = 0;
      reset_i     = 1'b1;
      set_stb_i   = 1'b0;
      set_addr_i  = '0;
      set_data_i  = '0;
      in_valid_i  = 1'b0;
      in_entry_i  = '0;
      strobe_i    = 1'b0;
      writes_done = 1'b0;
      rows[0] = make_row(64'h0000_0000_0000_0100, 4, 1'b0, 64'd0, 1'b0, 1'b0);
      rows[1] = make_row(64'h0000_0001_0000_0200, 3, 1'b1, 64'd30, 1'b0, 1'b0);
      rows[2] = make_row(64'h0000_0002_ffff_fff0, 2, 1'b1, 64'd40, 1'b0, 1'b0);  // lo carry
      rows[3] = make_row(64'h0000_0003_0000_1000, 2, 1'b1, -64'sd5, 1'b0, 1'b1);
      rows[4] = make_row(64'h0000_0004_0000_0000, 1, 1'b1, `VITA_MAX_LEAD + 64'd100,
                         1'b0, 1'b1);
      rows[5] = make_row(64'h0000_0005_0000_0000, 3, 1'b0, 64'd0, 1'b1, 1'b1);
      rows[6] = make_row(64'h0000_0006_0000_0000, 4, 1'b0, 64'd0, 1'b0, 1'b0);
      rows[7] = make_row(64'h0000_0007_0000_0000, 20, 1'b0, 64'd0, 1'b0, 1'b0);
      rows[8] = make_row(64'h0000_0008_0000_0050, 1, 1'b1, 64'd25, 1'b0, 1'b0);
      repeat (8) @(negedge clk);
      reset_i = 1'b0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(i);
      end
      $display("rows run: %0d, rows failed: %0d, errors: %0d", NUM_ROWS, rows_failed,
               error_count);
      if (error_count == 0 && rows_failed == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/vita_time_pkg.sv
logic/vita_tx_pkg.sv
logic/setting_reg.sv
logic/time_compare.sv
logic/vita_time_counter.sv
logic/sample_fifo.sv
logic/vita_tx_control.sv
logic/vita_tx_top.sv
test/vita_tx_checker.sv
test/vita_tx_tb.sv

// File: Bender.yml
package:
  name: vita_tx

sources:
  - include_dirs:
      - logic
    files:
      - logic/vita_time_pkg.sv
      - logic/vita_tx_pkg.sv
      - logic/setting_reg.sv
      - logic/time_compare.sv
      - logic/vita_time_counter.sv
      - logic/sample_fifo.sv
      - logic/vita_tx_control.sv
      - logic/vita_tx_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/vita_tx_checker.sv
      - test/vita_tx_tb.sv
